// ==== logic/fau_field_pkg.sv ====
// REG_SIZE must be a whole multiple of RADIX; primes and operands stay below 2^REG_SIZE
package fau_field_pkg;

    // ------------------------------------------------------------------------
    // Field and digit widths
    // ------------------------------------------------------------------------

    // Element width in bits
    localparam int REG_SIZE = 64;

    // Multiplier digit width, also the width of mu
    localparam int RADIX = 16;

    // Digits per element, one multiplier iteration each
    localparam int NUM_DIGITS = REG_SIZE / RADIX;

    // Digit counter width
    localparam int DIGIT_CNT_WIDTH = (NUM_DIGITS > 1) ? $clog2(NUM_DIGITS) : 1;

    // Accumulator holds T + b_i*A + q*N before the shift
    localparam int ACC_SIZE = REG_SIZE + RADIX + 1;

    // Start pulse to ready high again
    // Digit loop, then subtract and select
    localparam int MULT_LATENCY = NUM_DIGITS + 2;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------

    // One field element, unsigned
    typedef logic [REG_SIZE-1:0] field_elem_t;

    // One multiplier digit, unsigned
    typedef logic [RADIX-1:0] digit_t;

endpackage

// ==== logic/fau_op_pkg.sv ====
// Operation bundles only; widths come from fau_field_pkg, which must be compiled first
package fau_op_pkg;

    // ------------------------------------------------------------------------
    // Adder/subtractor control
    // ------------------------------------------------------------------------

    // sub selects a - b, red reduces into [0, prime)
    typedef struct packed {
        logic sub;
        logic red;
    } addsub_ctrl_t;

    // ------------------------------------------------------------------------
    // Multiplier operand bundle
    // ------------------------------------------------------------------------

    // Captured as a whole on start
    // mu is -prime^-1 mod 2^RADIX
    typedef struct packed {
        fau_field_pkg::field_elem_t opa;
        fau_field_pkg::field_elem_t opb;
        fau_field_pkg::field_elem_t prime;
        fau_field_pkg::digit_t      mu;
    } mont_operands_t;

endpackage

// ==== logic/montgomery_mult.sv ====
// Needs an odd prime below 2^REG_SIZE, operands below the prime and mu = -prime^-1 mod 2^RADIX
`timescale 1ns/10ps

module montgomery_mult (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       start_i,
    input  fau_op_pkg::mont_operands_t operands_i,
    output fau_field_pkg::field_elem_t p_o,
    output logic                       ready_o
);
    import fau_field_pkg::*;
    import fau_op_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOP,
        ST_SUB,
        ST_SEL
    } mult_state_t;

    mult_state_t                state_q;
    logic [DIGIT_CNT_WIDTH-1:0] cnt_q;
    logic                       use_diff_q;

    // Captured operands; opb shifts down one digit per iteration
    mont_operands_t             ops_q;
    logic [ACC_SIZE-1:0]        acc_q;
    field_elem_t                diff_q;

    digit_t                     b_digit;
    digit_t                     q_digit;
    logic [ACC_SIZE-1:0]        sum_ab;
    logic [ACC_SIZE-1:0]        sum_qn;
    logic [REG_SIZE+1:0]        final_diff;
    logic                       last_digit;

    // ------------------------------------------------------------------------
    // Digit step
    // ------------------------------------------------------------------------

    assign b_digit = ops_q.opb[RADIX-1:0];

    // T + b_i * A
    assign sum_ab = acc_q + b_digit * ops_q.opa;

    // Quotient digit clears the low digit of the sum
    assign q_digit = digit_t'(sum_ab[RADIX-1:0] * ops_q.mu);

    assign sum_qn = sum_ab + q_digit * ops_q.prime;

    assign last_digit = (cnt_q == DIGIT_CNT_WIDTH'(NUM_DIGITS - 1));

    // Accumulator is below 2*prime after the loop
    // MSB flags a borrow
    assign final_diff = {1'b0, acc_q[REG_SIZE:0]} - {2'b00, ops_q.prime};

    // ------------------------------------------------------------------------
    // Control FSM and result register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= ST_IDLE;
            cnt_q      <= '0;
            use_diff_q <= 1'b0;
            p_o        <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // Start while busy never reaches here
                    if (start_i) begin
                        state_q <= ST_LOOP;
                        cnt_q   <= '0;
                    end
                end
                ST_LOOP: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_digit) begin
                        state_q <= ST_SUB;
                    end
                end
                ST_SUB: begin
                    use_diff_q <= !final_diff[REG_SIZE+1];
                    state_q    <= ST_SEL;
                end
                ST_SEL: begin
                    p_o     <= use_diff_q ? diff_q : acc_q[REG_SIZE-1:0];
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Datapath registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                if (start_i) begin
                    ops_q <= operands_i;
                    acc_q <= '0;
                end
            end
            ST_LOOP: begin
                acc_q     <= sum_qn >> RADIX;
                ops_q.opb <= ops_q.opb >> RADIX;
            end
            ST_SUB: begin
                diff_q <= final_diff[REG_SIZE-1:0];
            end
            default: begin
            end
        endcase
    end

    assign ready_o = (state_q == ST_IDLE);

endmodule

// ==== logic/add_sub_mod.sv ====
// Reduced results are only correct for operands below the prime; hold inputs until ready_o
`timescale 1ns/10ps

module add_sub_mod (
    input  logic                       clk,
    input  logic                       reset_n,
    input  fau_op_pkg::addsub_ctrl_t   ctrl_i,
    input  fau_field_pkg::field_elem_t opa_i,
    input  fau_field_pkg::field_elem_t opb_i,
    input  fau_field_pkg::field_elem_t prime_i,
    output fau_field_pkg::field_elem_t res_o,
    output logic                       ready_o
);
    import fau_field_pkg::*;
    import fau_op_pkg::*;

    // Stage 1 copies of the inputs, kept for the ready compare
    addsub_ctrl_t        s1_ctrl_q;
    field_elem_t         s1_opa_q;
    field_elem_t         s1_opb_q;
    field_elem_t         s1_prime_q;

    // Raw result, MSB is carry or borrow
    logic [REG_SIZE:0]   s1_raw_q;

    // Stage 2 was built from inputs other than stage 1 holds
    logic                s2_stale_q;

    logic [REG_SIZE:0]   raw_res;
    logic [REG_SIZE+1:0] sum_minus_p;
    field_elem_t         corrected;
    logic                inputs_match;

    // ------------------------------------------------------------------------
    // Stage 1 arithmetic
    // ------------------------------------------------------------------------

    assign raw_res = ctrl_i.sub ? ({1'b0, opa_i} - {1'b0, opb_i})
                                : ({1'b0, opa_i} + {1'b0, opb_i});

    // ------------------------------------------------------------------------
    // Stage 2 correction
    // ------------------------------------------------------------------------

    // Top bit set means the sum is below the prime
    assign sum_minus_p = {1'b0, s1_raw_q} - {2'b00, s1_prime_q};

    always_comb begin
        if (!s1_ctrl_q.red) begin
            corrected = s1_raw_q[REG_SIZE-1:0];
        end else if (s1_ctrl_q.sub) begin
            // Borrow wraps back into range by adding the prime
            corrected = s1_raw_q[REG_SIZE] ? s1_raw_q[REG_SIZE-1:0] + s1_prime_q
                                           : s1_raw_q[REG_SIZE-1:0];
        end else begin
            corrected = sum_minus_p[REG_SIZE+1] ? s1_raw_q[REG_SIZE-1:0]
                                                : sum_minus_p[REG_SIZE-1:0];
        end
    end

    assign inputs_match = (ctrl_i == s1_ctrl_q) && (opa_i == s1_opa_q) &&
                          (opb_i == s1_opb_q) && (prime_i == s1_prime_q);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_ctrl_q  <= '0;
            s1_opa_q   <= '0;
            s1_opb_q   <= '0;
            s1_prime_q <= '0;
            s1_raw_q   <= '0;
            s2_stale_q <= 1'b0;
            res_o      <= '0;
        end else begin
            s1_ctrl_q  <= ctrl_i;
            s1_opa_q   <= opa_i;
            s1_opb_q   <= opb_i;
            s1_prime_q <= prime_i;
            s1_raw_q   <= raw_res;
            s2_stale_q <= !inputs_match;
            res_o      <= corrected;
        end
    end

    // Both stages must reflect what is on the inputs now
    assign ready_o = inputs_match && !s2_stale_q;

endmodule

// ==== logic/fau.sv ====
// sub_i/red_i act one cycle late; a multiply starts only on a rising edge of mult_start_i
`timescale 1ns/10ps

module fau (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       sub_i,
    input  logic                       red_i,
    input  logic                       mult_start_i,
    input  fau_field_pkg::field_elem_t prime_i,
    input  fau_field_pkg::digit_t      mult_mu_i,
    input  fau_field_pkg::field_elem_t opa_i,
    input  fau_field_pkg::field_elem_t opb_i,
    output fau_field_pkg::field_elem_t add_res_o,
    output fau_field_pkg::field_elem_t mult_res_o,
    output logic                       ready_o
);
    import fau_op_pkg::*;

    addsub_ctrl_t   ctrl_q;
    mont_operands_t mult_ops;

    logic           mult_start_q;
    logic           mult_start_dly_q;
    logic           mult_start_pulse;
    logic           mult_ready;
    logic           add_ready;

    // ------------------------------------------------------------------------
    // Strobe registers and start edge detect
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_q           <= '0;
            mult_start_q     <= 1'b0;
            mult_start_dly_q <= 1'b0;
        end else begin
            ctrl_q.sub       <= sub_i;
            ctrl_q.red       <= red_i;
            mult_start_q     <= mult_start_i;
            mult_start_dly_q <= mult_start_q;
        end
    end

    // One cycle high per rising edge of the start level
    assign mult_start_pulse = mult_start_q & ~mult_start_dly_q;

    assign mult_ops.opa   = opa_i;
    assign mult_ops.opb   = opb_i;
    assign mult_ops.prime = prime_i;
    assign mult_ops.mu    = mult_mu_i;

    // ------------------------------------------------------------------------
    // Engines
    // ------------------------------------------------------------------------

    montgomery_mult mult_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (mult_start_pulse),
        .operands_i (mult_ops),
        .p_o        (mult_res_o),
        .ready_o    (mult_ready)
    );

    add_sub_mod add_sub_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .ctrl_i  (ctrl_q),
        .opa_i   (opa_i),
        .opb_i   (opb_i),
        .prime_i (prime_i),
        .res_o   (add_res_o),
        .ready_o (add_ready)
    );

    assign ready_o = add_ready & mult_ready;

endmodule

// ==== verif/fau_checker.sv ====
// Bound into fau; needs its internal start pulse and multiplier ready, counts failures
`timescale 1ns/10ps

module fau_checker (
    input logic clk,
    input logic reset_n,
    input logic start_pulse_i,
    input logic mult_ready_i,
    input logic fau_ready_i
);

    // Read by the testbench at the end of the run
    int failures = 0;

    // Edge detect gives one cycle per rising edge
    a_single_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        start_pulse_i |=> !start_pulse_i)
    else begin
        $error("start pulse high on two consecutive cycles");
        failures++;
    end

    a_busy_after_start: assert property (@(posedge clk) disable iff (!reset_n)
        (start_pulse_i && mult_ready_i) |=> !mult_ready_i)
    else begin
        $error("multiplier still ready after an accepted start");
        failures++;
    end

    a_ready_after_reset: assert property (@(posedge clk)
        $rose(reset_n) |-> fau_ready_i)
    else begin
        $error("ready low in the first cycle after reset");
        failures++;
    end

endmodule

// ==== verif/fau_tb.sv ====
// Expects odd primes below 2^REG_SIZE and operands below the prime; one clock, no back-pressure
`timescale 1ns/10ps

module fau_tb;
    import fau_field_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_ROWS   = 10;
    localparam int RAND_SEED  = 80197;
    localparam int WAIT_LIMIT = MULT_LATENCY + 8;
    // Reset and the two start tests take about one row each
    localparam int WATCHDOG_CYCLES = (NUM_ROWS + 3) * (MULT_LATENCY + 10);

    typedef struct packed {
        field_elem_t prime;
        field_elem_t opa;
        field_elem_t opb;
        logic        sub;
        logic        red;
        logic        rnd;
        field_elem_t exp_add;
    } stim_row_t;

    logic        clk;
    logic        reset_n;
    logic        sub_i;
    logic        red_i;
    logic        mult_start_i;
    field_elem_t prime_i;
    digit_t      mult_mu_i;
    field_elem_t opa_i;
    field_elem_t opb_i;
    field_elem_t add_res_o;
    field_elem_t mult_res_o;
    logic        ready_o;

    stim_row_t   rows [NUM_ROWS];
    int          row_count;

    fau fau_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .sub_i        (sub_i),
        .red_i        (red_i),
        .mult_start_i (mult_start_i),
        .prime_i      (prime_i),
        .mult_mu_i    (mult_mu_i),
        .opa_i        (opa_i),
        .opb_i        (opb_i),
        .add_res_o    (add_res_o),
        .mult_res_o   (mult_res_o),
        .ready_o      (ready_o)
    );

    bind fau fau_checker checker_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .start_pulse_i (mult_start_pulse),
        .mult_ready_i  (mult_ready),
        .fau_ready_i   (ready_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // Reference rules and compare tasks
    // ------------------------------------------------------------------------

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1);
    endtask

    function automatic field_elem_t expected_add(input stim_row_t row);
        logic [REG_SIZE:0] wide;
        field_elem_t       result;
        wide = row.sub ? ({1'b0, row.opa} - {1'b0, row.opb})
                       : ({1'b0, row.opa} + {1'b0, row.opb});
        result = wide[REG_SIZE-1:0];
        if (row.red && row.sub && (row.opa < row.opb)) begin
            result = wide[REG_SIZE-1:0] + row.prime;
        end else if (row.red && !row.sub && (wide >= {1'b0, row.prime})) begin
            result = field_elem_t'(wide - {1'b0, row.prime});
        end
        return result;
    endfunction

    // Newton steps on -prime^-1, each one doubles the correct low bits
    function automatic digit_t neg_inverse(input field_elem_t prime);
        digit_t p_lo;
        digit_t inv;
        int     bits;
        p_lo = prime[RADIX-1:0];
        inv  = digit_t'(1);
        for (bits = 1; bits < RADIX; bits = bits * 2) begin
            inv = digit_t'(inv * digit_t'(digit_t'(2) - digit_t'(p_lo * inv)));
        end
        return digit_t'(-inv);
    endfunction

    task automatic check_add(input field_elem_t got, input field_elem_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at time %0t: %s, got %h expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at time %0t: %s, got %b expected %b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            report_failure($sformatf("mismatch at time %0t: %s, got %0d cycles expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    // got * 2^REG_SIZE must match opa * opb, both mod prime
    task automatic check_mult(input field_elem_t got, input field_elem_t opa,
                              input field_elem_t opb, input field_elem_t prime,
                              input string what);
        logic [2*REG_SIZE-1:0] wide_p;
        logic [2*REG_SIZE-1:0] lhs;
        logic [2*REG_SIZE-1:0] rhs;
        wide_p = {{REG_SIZE{1'b0}}, prime};
        lhs    = {got, {REG_SIZE{1'b0}}} % wide_p;
        rhs    = ({{REG_SIZE{1'b0}}, opa} * {{REG_SIZE{1'b0}}, opb}) % wide_p;
        if ($isunknown(got) || (got >= prime) || (lhs != rhs)) begin
            report_failure($sformatf("mismatch at time %0t: %s, got %h for %h * %h mod %h",
                                     $time, what, got, opa, opb, prime));
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------

    task automatic add_row(input field_elem_t prime, input field_elem_t opa,
                           input field_elem_t opb, input logic sub, input logic red,
                           input logic rnd, input field_elem_t exp_add);
        rows[row_count].prime   = prime;
        rows[row_count].opa     = opa;
        rows[row_count].opb     = opb;
        rows[row_count].sub     = sub;
        rows[row_count].red     = red;
        rows[row_count].rnd     = rnd;
        rows[row_count].exp_add = exp_add;
        row_count = row_count + 1;
    endtask

    task automatic load_table();
        int i;
        row_count = 0;
        // Sum crosses 97, difference borrows, then the same in raw mode
        add_row(64'h61, 64'h50, 64'h30, 1'b0, 1'b1, 1'b0, 64'h1F);
        add_row(64'h61, 64'h10, 64'h20, 1'b1, 1'b1, 1'b0, 64'h51);
        add_row(64'h61, 64'h10, 64'h20, 1'b1, 1'b0, 1'b0, 64'hFFFF_FFFF_FFFF_FFF0);
        // Largest 64-bit prime, carry out of the element width
        add_row(64'hFFFF_FFFF_FFFF_FFC5, 64'hFFFF_FFFF_FFFF_FFC0, 64'h50,
                1'b0, 1'b1, 1'b0, 64'h4B);
        add_row(64'hFFFF_FFFF_FFFF_FFC5, 64'h5, 64'hFFFF_FFFF_FFFF_FFC0,
                1'b1, 1'b1, 1'b0, 64'hA);
        add_row(64'hFFFF_FFFF_FFFF_FFC5, 64'hFFFF_FFFF_FFFF_FFC0, 64'h50,
                1'b0, 1'b0, 1'b0, 64'h10);
        add_row(64'hFFFF_FFFF_0000_0001, 64'h1234_5678_9ABC_DEF0, 64'h0FED_CBA9_8765_4321,
                1'b0, 1'b1, 1'b0, 64'h2222_2222_2222_2211);
        // Operands and expected values filled in below
        add_row(64'h1FFF_FFFF_FFFF_FFFF, '0, '0, 1'b0, 1'b1, 1'b1, '0);
        add_row(64'hFFFF_FFFF_0000_0001, '0, '0, 1'b1, 1'b1, 1'b1, '0);
        add_row(64'h10001, '0, '0, 1'b0, 1'b0, 1'b1, '0);
        for (i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].rnd) begin
                rows[i].opa     = field_elem_t'({$urandom, $urandom}) % rows[i].prime;
                rows[i].opb     = field_elem_t'({$urandom, $urandom}) % rows[i].prime;
                rows[i].exp_add = expected_add(rows[i]);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------------------

    task automatic wait_ready(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (ready_o !== 1'b1) begin
            waited = waited + 1;
            if (waited > WAIT_LIMIT) begin
                report_failure($sformatf("Ready never came back for %s", what));
            end
            @(negedge clk);
        end
    endtask

    // Counts rising edges from the start drive until ready is seen low then high
    task automatic run_multiply(input int change_at, output int cycles);
        logic seen_low;
        logic done;
        cycles   = 0;
        seen_low = 1'b0;
        done     = 1'b0;
        @(posedge clk);
        #2 mult_start_i = 1'b1;
        while (!done) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles == change_at) begin
                #2 opa_i = opa_i ^ 64'h5A5A_5A5A_5A5A_5A5A;
            end
            @(negedge clk);
            if (ready_o !== 1'b1) begin
                seen_low = 1'b1;
            end else if (seen_low) begin
                done = 1'b1;
            end
            if (!done && (cycles > WAIT_LIMIT)) begin
                report_failure("The multiplier did not return ready in time");
            end
        end
    endtask

    task automatic release_start();
        @(posedge clk);
        #2 mult_start_i = 1'b0;
    endtask

    task automatic apply_row(input stim_row_t row, input int index);
        int    cycles;
        string tag;
        tag = $sformatf("row %0d", index);
        @(posedge clk);
        #2;
        prime_i   = row.prime;
        mult_mu_i = neg_inverse(row.prime);
        opa_i     = row.opa;
        opb_i     = row.opb;
        sub_i     = row.sub;
        red_i     = row.red;
        // Control strobes reach the adder one cycle late
        @(posedge clk);
        wait_ready({tag, " add/sub"});
        check_add(add_res_o, row.exp_add, {tag, " add/sub result"});
        run_multiply(0, cycles);
        check_latency(cycles, MULT_LATENCY + 2, {tag, " multiply latency"});
        check_mult(mult_res_o, row.opa, row.opb, row.prime, {tag, " product"});
        release_start();
    endtask

    initial begin
        int          i;
        int          cycles;
        stim_row_t   last_row;
        clk          = 1'b0;
        reset_n      = 1'b0;
        sub_i        = 1'b0;
        red_i        = 1'b0;
        mult_start_i = 1'b0;
        prime_i      = '0;
        mult_mu_i    = '0;
        opa_i        = '0;
        opb_i        = '0;
        void'($urandom(RAND_SEED));
        load_table();
        repeat (2) @(posedge clk);
        #2 reset_n = 1'b1;
        @(negedge clk);
        check_ready(ready_o, 1'b1, "ready after reset");
        check_add(add_res_o, '0, "add result after reset");
        if (mult_res_o !== '0) begin
            report_failure($sformatf("mismatch at time %0t: product after reset is %h",
                                     $time, mult_res_o));
        end
        for (i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i], i);
        end
        // Start held high over a second product window runs only once
        last_row = rows[NUM_ROWS-1];
        run_multiply(0, cycles);
        check_latency(cycles, MULT_LATENCY + 2, "held start latency");
        check_mult(mult_res_o, last_row.opa, last_row.opb, last_row.prime, "held start");
        repeat (MULT_LATENCY + 2) begin
            @(negedge clk);
            check_ready(ready_o, 1'b1, "ready with start held high");
        end
        release_start();
        // opa moves after capture, product follows the captured copy
        run_multiply(3, cycles);
        check_latency(cycles, MULT_LATENCY + 2, "opa changed latency");
        check_mult(mult_res_o, last_row.opa, last_row.opb, last_row.prime, "opa changed");
        release_start();
        if (fau_inst.checker_inst.failures != 0) begin
            report_failure("Bound assertions failed during the run");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("The run timed out after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $fatal(1);
    end

endmodule

// ==== list.f ====
logic/fau_field_pkg.sv
logic/fau_op_pkg.sv
logic/montgomery_mult.sv
logic/add_sub_mod.sv
logic/fau.sv
verif/fau_checker.sv
verif/fau_tb.sv

// ==== Bender.yml ====
package:
  name: fau

sources:
  - logic/fau_field_pkg.sv
  - logic/fau_op_pkg.sv
  - logic/montgomery_mult.sv
  - logic/add_sub_mod.sv
  - logic/fau.sv
  - target: verif
    files:
      - verif/fau_checker.sv
      - verif/fau_tb.sv
